/* hw/conv_types_pkg.sv */
/*
  Data formats shared by the convolution datapath.
  Buffers hold 32-bit words of four signed bytes, lowest byte first.
*/
`default_nettype none

package conv_types_pkg;

  // one buffer word or one register value
  typedef logic [31:0] word_t;

  // signed int8 sample as stored in the buffers
  typedef logic signed [7:0] byte_t;

  // running dot product, wraps at 32 bits
  typedef logic signed [31:0] acc_t;

  // full product inside the requantizer
  typedef logic signed [63:0] wide_t;

  // byte address into either buffer
  typedef logic [15:0] byte_addr_t;

  // word index into either buffer
  typedef logic [13:0] word_addr_t;

  // four consecutive words, lowest word in the low bits
  typedef logic [127:0] lanes_t;

  // one address step of the window walk
  typedef struct packed {
    word_addr_t in_word;
    word_addr_t flt_word;
    logic       valid;
    logic       last;
  } step_t;

  // bytes consumed per step and the words they span
  localparam int STEP_BYTES     = 16;
  localparam int WORDS_PER_STEP = 4;

endpackage

`default_nettype wire

/* hw/conv_bus_pkg.sv */
/*
  Wishbone classic bus structs, register map and configuration records.
  Configuration registers are write-only and read back as 0.
*/
`default_nettype none

package conv_bus_pkg;
  import conv_types_pkg::*;

  // request from the host, adr is a word address
  typedef struct packed {
    logic [11:0] adr;
    word_t       dat;
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_req_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  // layer geometry and the input zero point
  typedef struct packed {
    word_t input_offset;
    word_t input_depth;
    word_t input_width;
    word_t start_input_x;
    word_t start_filter_x;
  } layer_cfg_t;

  // requantization of the final sum
  typedef struct packed {
    word_t bias;
    word_t multiplier;
    word_t shift;
    word_t act_min;
    word_t act_max;
    word_t output_offset;
  } quant_cfg_t;

  // region select lives in adr[11:10]
  localparam logic [1:0] REGION_REGS   = 2'd0;
  localparam logic [1:0] REGION_INPUT  = 2'd1;
  localparam logic [1:0] REGION_FILTER = 2'd2;

  // register index lives in adr[9:0]
  localparam logic [9:0] REG_INPUT_OFFSET = 10'd0;
  localparam logic [9:0] REG_DEPTH        = 10'd1;
  localparam logic [9:0] REG_WIDTH        = 10'd2;
  localparam logic [9:0] REG_START_IN     = 10'd3;
  localparam logic [9:0] REG_START_FLT    = 10'd4;
  localparam logic [9:0] REG_BIAS         = 10'd5;
  localparam logic [9:0] REG_MULT         = 10'd6;
  localparam logic [9:0] REG_SHIFT        = 10'd7;
  localparam logic [9:0] REG_ACT_MIN      = 10'd8;
  localparam logic [9:0] REG_ACT_MAX      = 10'd9;
  localparam logic [9:0] REG_OUT_OFFSET   = 10'd10;
  localparam logic [9:0] REG_CONTROL      = 10'd11;
  localparam logic [9:0] REG_RESULT       = 10'd12;

  // control register bits, a write of bit 0 requests a start
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_BUSY_BIT  = 0;
  localparam int CTRL_DONE_BIT  = 1;

endpackage

`default_nettype wire

/* hw/conv_regs.sv */
/*
  Wishbone classic slave with no wait states, ack one cycle after the request.
  Buffers are write-only, a start while busy is dropped.
*/
`timescale 1ns/100ps
`default_nettype none

module conv_regs import conv_types_pkg::*, conv_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  output layer_cfg_t layer_cfg,
  output quant_cfg_t quant_cfg,
  output logic       start,
  output logic       in_we,
  output logic       flt_we,
  output word_addr_t wr_word,
  output word_t      wr_data,
  input  word_t      result,
  input  logic       result_valid
);

  logic       ack;
  logic       accept;
  logic       wr_accept;
  logic [1:0] region;
  logic [9:0] reg_idx;
  logic       reg_wr;
  logic       start_req;
  logic       busy;
  logic       done;
  word_t      rd_mux;
  word_t      rd_data;
  word_t      result_q;

  // a live request is taken unless it is the one just acked
  assign accept    = wb_req.cyc && wb_req.stb && !ack;
  assign wr_accept = accept && wb_req.we;
  assign region    = wb_req.adr[11:10];
  assign reg_idx   = wb_req.adr[9:0];
  assign reg_wr    = wr_accept && (region == REGION_REGS);

  // buffer writes land on the same edge that samples the request
  assign in_we   = wr_accept && (region == REGION_INPUT);
  assign flt_we  = wr_accept && (region == REGION_FILTER);
  assign wr_word = word_addr_t'(reg_idx);
  assign wr_data = wb_req.dat;

  assign start_req = reg_wr && (reg_idx == REG_CONTROL) &&
                     wb_req.dat[CTRL_START_BIT] && !busy;

  // configuration registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_cfg <= '0;
      quant_cfg <= '0;
    end else if (reg_wr) begin
      case (reg_idx)
        REG_INPUT_OFFSET: layer_cfg.input_offset   <= wb_req.dat;
        REG_DEPTH:        layer_cfg.input_depth    <= wb_req.dat;
        REG_WIDTH:        layer_cfg.input_width    <= wb_req.dat;
        REG_START_IN:     layer_cfg.start_input_x  <= wb_req.dat;
        REG_START_FLT:    layer_cfg.start_filter_x <= wb_req.dat;
        REG_BIAS:         quant_cfg.bias           <= wb_req.dat;
        REG_MULT:         quant_cfg.multiplier     <= wb_req.dat;
        REG_SHIFT:        quant_cfg.shift          <= wb_req.dat;
        REG_ACT_MIN:      quant_cfg.act_min        <= wb_req.dat;
        REG_ACT_MAX:      quant_cfg.act_max        <= wb_req.dat;
        REG_OUT_OFFSET:   quant_cfg.output_offset  <= wb_req.dat;
        default: ;
      endcase
    end
  end

  // start wins over a result that finishes in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      start <= 1'b0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      ack   <= accept;
      start <= start_req;
      if (start_req) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (result_valid) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // only status and result are readable, everything else reads 0
  always_comb begin
    rd_mux = '0;
    if (region == REGION_REGS) begin
      if (reg_idx == REG_CONTROL) begin
        rd_mux[CTRL_BUSY_BIT] = busy;
        rd_mux[CTRL_DONE_BIT] = done;
      end else if (reg_idx == REG_RESULT) begin
        rd_mux = result_q;
      end
    end
  end

  // the result reads 0 until the first run finishes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data  <= '0;
      result_q <= '0;
    end else begin
      if (accept) begin
        rd_data <= wb_req.we ? '0 : rd_mux;
      end
      if (result_valid) begin
        result_q <= result;
      end
    end
  end

  assign wb_rsp = '{dat: rd_data, ack: ack};

endmodule

`default_nettype wire

/* hw/word_buffer.sv */
/*
  Word memory with one write port and a registered four-word read.
  WORDS must be a power of two, read indices wrap at WORDS.
*/
`timescale 1ns/100ps
`default_nettype none

module word_buffer import conv_types_pkg::*; #(
  parameter int WORDS = 256
) (
  input  logic       clk,
  input  logic       we,
  input  word_addr_t wr_word,
  input  word_t      wr_data,
  input  word_addr_t rd_word,
  output lanes_t     rd_data
);

  localparam int IDX_W = $clog2(WORDS);

  word_t            mem [WORDS];
  logic [IDX_W-1:0] rd_idx [WORDS_PER_STEP];

  // consecutive words, the low index bits wrap around the end of the memory
  always_comb begin
    for (int w = 0; w < WORDS_PER_STEP; w++) begin
      rd_idx[w] = rd_word[IDX_W-1:0] + IDX_W'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_word[IDX_W-1:0]] <= wr_data;
    end
    // word 0 of the step goes to the lowest lane bits
    for (int w = 0; w < WORDS_PER_STEP; w++) begin
      rd_data[32*w +: 32] <= mem[rd_idx[w]];
    end
  end

endmodule

`default_nettype wire

/* hw/window_sequencer.sv */
/*
  Walks the filter and input ranges 16 bytes per cycle after a start.
  Assumes input_depth is a multiple of 16, byte addresses are 16 bits wide.
*/
`timescale 1ns/100ps
`default_nettype none

module window_sequencer import conv_types_pkg::*, conv_bus_pkg::*; #(
  parameter int KERNEL_LENGTH = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  layer_cfg_t layer_cfg,
  output step_t      step
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_RUN
  } seq_state_t;

  seq_state_t  state;
  byte_addr_t  flt_addr;
  byte_addr_t  flt_end;
  byte_addr_t  in_addr;
  byte_addr_t  in_end;
  logic [16:0] flt_next;
  logic [16:0] in_next;
  logic        step_valid;
  logic        step_last;

  // one extra bit keeps the end test honest near the top of the address space
  assign flt_next = {1'b0, flt_addr} + 17'(STEP_BYTES);
  assign in_next  = {1'b0, in_addr} + 17'(STEP_BYTES);

  // an empty window still sends one step so the accumulator releases a zero
  assign step_valid = (flt_addr < flt_end) && (in_addr < in_end);
  assign step_last  = !step_valid ||
                      (flt_next >= {1'b0, flt_end}) ||
                      (in_next >= {1'b0, in_end});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      flt_addr <= '0;
      flt_end  <= '0;
      in_addr  <= '0;
      in_end   <= '0;
      step     <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          step <= '0;
          if (start) begin
            // the multiplies get the whole setup cycle to settle
            flt_addr <= byte_addr_t'(layer_cfg.start_filter_x * layer_cfg.input_depth);
            flt_end  <= byte_addr_t'(word_t'(KERNEL_LENGTH) * layer_cfg.input_depth);
            in_addr  <= byte_addr_t'(layer_cfg.start_input_x * layer_cfg.input_depth);
            in_end   <= byte_addr_t'(layer_cfg.input_width * layer_cfg.input_depth);
            state    <= S_SETUP;
          end
        end
        S_SETUP, S_RUN: begin
          // issue the current addresses and move both ranges forward
          step.in_word  <= in_addr[15:2];
          step.flt_word <= flt_addr[15:2];
          step.valid    <= step_valid;
          step.last     <= step_last;
          flt_addr      <= flt_next[15:0];
          in_addr       <= in_next[15:0];
          state         <= step_last ? S_IDLE : S_RUN;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/dot_accumulator.sv */
/*
  Sixteen-lane int8 multiply-add with the input zero point added per lane.
  Sums wrap at 32 bits, one total leaves per last step.
*/
`timescale 1ns/100ps
`default_nettype none

module dot_accumulator import conv_types_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   valid,
  input  logic   last,
  input  lanes_t in_lanes,
  input  lanes_t flt_lanes,
  input  word_t  input_offset,
  output acc_t   acc,
  output logic   acc_valid
);

  acc_t step_sum;
  acc_t sum_q;
  acc_t total;

  // lane 0 is the low byte of the lowest word
  always_comb begin
    byte_t in_byte;
    byte_t flt_byte;
    step_sum = '0;
    for (int l = 0; l < STEP_BYTES; l++) begin
      in_byte  = in_lanes[8*l +: 8];
      flt_byte = flt_lanes[8*l +: 8];
      step_sum = step_sum +
                 acc_t'(flt_byte) * (acc_t'(in_byte) + acc_t'(input_offset));
    end
  end

  // a step without data adds nothing but can still close the window
  assign total = valid ? sum_q + step_sum : sum_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q     <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= last;
      if (last) begin
        // start the next window from zero
        sum_q <= '0;
      end else begin
        sum_q <= total;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last) begin
      acc <= total;
    end
  end

endmodule

`default_nettype wire

/* hw/requantizer.sv */
/*
  Two-stage requantizer: (acc + bias) * multiplier, arithmetic shift right,
  add output_offset, clamp to act_min..act_max. No rounding is applied.
*/
`timescale 1ns/100ps
`default_nettype none

module requantizer import conv_types_pkg::*, conv_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  acc_t       acc,
  input  logic       acc_valid,
  input  quant_cfg_t quant_cfg,
  output word_t      result,
  output logic       result_valid
);

  acc_t  biased;
  wide_t prod_q;
  logic  prod_valid;
  wide_t shifted;
  acc_t  offset_sum;
  acc_t  act_min;
  acc_t  act_max;
  acc_t  clamped;

  // the bias add wraps at 32 bits before the widening multiply
  assign biased = acc + acc_t'(quant_cfg.bias);

  // only the low 6 bits of shift matter for a 64-bit product
  assign shifted    = prod_q >>> quant_cfg.shift[5:0];
  assign offset_sum = acc_t'(shifted[31:0]) + acc_t'(quant_cfg.output_offset);

  assign act_min = acc_t'(quant_cfg.act_min);
  assign act_max = acc_t'(quant_cfg.act_max);

  always_comb begin
    if (offset_sum < act_min) begin
      clamped = act_min;
    end else if (offset_sum > act_max) begin
      clamped = act_max;
    end else begin
      clamped = offset_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid   <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      prod_valid   <= acc_valid;
      result_valid <= prod_valid;
    end
  end

  // stage 1 product and stage 2 result, one item may sit in each
  always_ff @(posedge clk) begin
    prod_q <= wide_t'(biased) * wide_t'(acc_t'(quant_cfg.multiplier));
    result <= word_t'(clamped);
  end

endmodule

`default_nettype wire

/* hw/conv1d_top.sv */
/*
  1-D int8 convolution accelerator behind a Wishbone classic slave.
  KERNEL_LENGTH, INPUT_WORDS and FILTER_WORDS must be powers of two within 16K.
*/
`timescale 1ns/100ps
`default_nettype none

module conv1d_top import conv_types_pkg::*, conv_bus_pkg::*; #(
  parameter int KERNEL_LENGTH = 8,
  parameter int INPUT_WORDS   = 256,
  parameter int FILTER_WORDS  = 64
) (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  layer_cfg_t layer_cfg;
  quant_cfg_t quant_cfg;
  logic       start;
  logic       in_we;
  logic       flt_we;
  word_addr_t wr_word;
  word_t      wr_data;
  step_t      step;
  lanes_t     in_lanes;
  lanes_t     flt_lanes;
  logic       step_valid_q;
  logic       step_last_q;
  acc_t       acc;
  logic       acc_valid;
  word_t      result;
  logic       result_valid;

  conv_regs i_regs (
    .clk, .rst_n, .wb_req, .wb_rsp, .layer_cfg, .quant_cfg, .start,
    .in_we, .flt_we, .wr_word, .wr_data, .result, .result_valid
  );

  window_sequencer #(.KERNEL_LENGTH(KERNEL_LENGTH)) i_seq (
    .clk, .rst_n, .start, .layer_cfg, .step
  );

  word_buffer #(.WORDS(INPUT_WORDS)) i_in_buf (
    .clk, .we(in_we), .wr_word, .wr_data, .rd_word(step.in_word), .rd_data(in_lanes)
  );

  word_buffer #(.WORDS(FILTER_WORDS)) i_flt_buf (
    .clk, .we(flt_we), .wr_word, .wr_data, .rd_word(step.flt_word), .rd_data(flt_lanes)
  );

  // valid and last ride one cycle behind the step to meet the buffer data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_valid_q <= 1'b0;
      step_last_q  <= 1'b0;
    end else begin
      step_valid_q <= step.valid;
      step_last_q  <= step.last;
    end
  end

  dot_accumulator i_dot (
    .clk, .rst_n, .valid(step_valid_q), .last(step_last_q), .in_lanes, .flt_lanes,
    .input_offset(layer_cfg.input_offset), .acc, .acc_valid
  );

  requantizer i_quant (
    .clk, .rst_n, .acc, .acc_valid, .quant_cfg, .result, .result_valid
  );

endmodule

`default_nettype wire

/* verification/conv1d_sva.sv */
/*
  Bound checks on the Wishbone handshake and the busy/done status pair.
  Bound into conv1d_top, status bits are taken from the register block.
*/
`timescale 1ns/100ps
`default_nettype none

module conv1d_sva import conv_bus_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input wb_req_t wb_req,
  input wb_rsp_t wb_rsp,
  input logic    busy,
  input logic    done
);

  logic live;

  // a request is live while both cyc and stb are high
  assign live = wb_req.cyc && wb_req.stb;

  // the slave acks for a single cycle and then takes a break
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack was high two cycles in a row");

  // every ack answers a request seen on the cycle before
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> $past(live))
    else $error("ack without a live request in the previous cycle");

  // a run is either in progress or finished, never both
  a_status_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy && done))
    else $error("busy and done high together");

endmodule

bind conv1d_top conv1d_sva i_sva (
  .clk(clk),
  .rst_n(rst_n),
  .wb_req(wb_req),
  .wb_rsp(wb_rsp),
  .busy(i_regs.busy),
  .done(i_regs.done)
);

`default_nettype wire

/* verification/conv1d_tb.sv */
/*
  Directed testbench for the conv1d accelerator over Wishbone classic.
  Buffer contents are mirrored here, expected results come from a model of the
  dot-product and requantization rules. Assumes input_depth is a multiple of 16.
*/
`timescale 1ns/100ps
`default_nettype none

module conv1d_tb import conv_types_pkg::*, conv_bus_pkg::*; ();

  localparam int    KERNEL_LENGTH  = 8;
  localparam int    INPUT_WORDS    = 256;
  localparam int    FILTER_WORDS   = 64;
  localparam int    TIMEOUT_CYCLES = 20000;
  localparam int    ACK_LIMIT      = 8;
  localparam int    POLL_LIMIT     = 100;
  localparam word_t WIDE_MIN       = 32'h8000_0000;
  localparam word_t WIDE_MAX       = 32'h7fff_ffff;

  logic       clk = 1'b0;
  logic       rst_n;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  word_t      in_mem [INPUT_WORDS];
  word_t      flt_mem [FILTER_WORDS];
  layer_cfg_t lcfg;
  quant_cfg_t qcfg;
  word_t      lfsr_state = 32'hf221;
  string      cur_test;
  int         cycle_count = 0;
  int         error_count = 0;
  int         test_errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;

  conv1d_top #(
    .KERNEL_LENGTH(KERNEL_LENGTH),
    .INPUT_WORDS(INPUT_WORDS),
    .FILTER_WORDS(FILTER_WORDS)
  ) i_dut (
    .clk(clk),
    .rst_n(rst_n),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
  );

  // 20 ns clock period
  always #10 clk = ~clk;

  // hard stop in case a handshake or the done bit never arrives
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic word_t lfsr_next(word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken, the newest bit lands at the bottom
  function automatic word_t take_bits(int n);
    word_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic logic [11:0] reg_adr(logic [9:0] idx);
    return {REGION_REGS, idx};
  endfunction

  // one classic cycle, request on a rising edge and ack sampled mid-cycle
  task automatic bus_cycle(logic [11:0] adr, logic we, word_t dat, output word_t rdat);
    wb_req_t req;
    int      waited;
    req.adr = adr;
    req.dat = dat;
    req.we  = we;
    req.stb = 1'b1;
    req.cyc = 1'b1;
    waited  = 0;
    @(posedge clk);
    wb_req <= req;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < ACK_LIMIT);
    if (!wb_rsp.ack) begin
      $display("ERROR %s: no ack within %0d cycles at address %h", cur_test, ACK_LIMIT, adr);
      error_count++;
    end
    rdat = wb_rsp.dat;
    // the master lets go of stb once it has seen ack
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_write(logic [11:0] adr, word_t dat);
    word_t unused;
    bus_cycle(adr, 1'b1, dat, unused);
  endtask

  task automatic wb_read(logic [11:0] adr, output word_t rdat);
    bus_cycle(adr, 1'b0, '0, rdat);
  endtask

  task automatic set_layer(word_t offset, word_t depth, word_t width, word_t six, word_t sfx);
    lcfg.input_offset   = offset;
    lcfg.input_depth    = depth;
    lcfg.input_width    = width;
    lcfg.start_input_x  = six;
    lcfg.start_filter_x = sfx;
    wb_write(reg_adr(REG_INPUT_OFFSET), offset);
    wb_write(reg_adr(REG_DEPTH), depth);
    wb_write(reg_adr(REG_WIDTH), width);
    wb_write(reg_adr(REG_START_IN), six);
    wb_write(reg_adr(REG_START_FLT), sfx);
  endtask

  task automatic set_quant(word_t bias, word_t mult, word_t shift, word_t amin, word_t amax,
                           word_t oofs);
    qcfg.bias          = bias;
    qcfg.multiplier    = mult;
    qcfg.shift         = shift;
    qcfg.act_min       = amin;
    qcfg.act_max       = amax;
    qcfg.output_offset = oofs;
    wb_write(reg_adr(REG_BIAS), bias);
    wb_write(reg_adr(REG_MULT), mult);
    wb_write(reg_adr(REG_SHIFT), shift);
    wb_write(reg_adr(REG_ACT_MIN), amin);
    wb_write(reg_adr(REG_ACT_MAX), amax);
    wb_write(reg_adr(REG_OUT_OFFSET), oofs);
  endtask

  // both buffers get random words, the mirror keeps a copy for the model
  task automatic fill_buffers();
    for (int w = 0; w < INPUT_WORDS; w++) begin
      in_mem[w] = take_bits(32);
      wb_write({REGION_INPUT, 10'(w)}, in_mem[w]);
    end
    for (int w = 0; w < FILTER_WORDS; w++) begin
      flt_mem[w] = take_bits(32);
      wb_write({REGION_FILTER, 10'(w)}, flt_mem[w]);
    end
  endtask

  // byte a sits in word a/4, lowest byte of a word first
  function automatic byte_t input_byte(int a);
    return in_mem[(a / 4) % INPUT_WORDS][8 * (a % 4) +: 8];
  endfunction

  function automatic byte_t filter_byte(int a);
    return flt_mem[(a / 4) % FILTER_WORDS][8 * (a % 4) +: 8];
  endfunction

  // the window stops at whichever range runs out first, in whole 16-byte steps
  function automatic acc_t dot_model();
    int   depth;
    int   k_start;
    int   k_len;
    int   i_start;
    int   i_len;
    int   len;
    acc_t sum;
    depth   = int'(lcfg.input_depth);
    k_start = int'(lcfg.start_filter_x) * depth;
    k_len   = KERNEL_LENGTH * depth - k_start;
    i_start = int'(lcfg.start_input_x) * depth;
    i_len   = int'(lcfg.input_width) * depth - i_start;
    len     = (k_len < i_len) ? k_len : i_len;
    sum     = '0;
    if (len > 0) begin
      len = (len + STEP_BYTES - 1) / STEP_BYTES * STEP_BYTES;
    end
    for (int b = 0; b < len; b++) begin
      sum += acc_t'(filter_byte(k_start + b)) *
             (acc_t'(input_byte(i_start + b)) + acc_t'(lcfg.input_offset));
    end
    return sum;
  endfunction

  // bias wraps at 32 bits, then a full signed product, shift, offset and clamp
  function automatic word_t requant_model(acc_t acc, quant_cfg_t q);
    acc_t   biased;
    longint prod;
    acc_t   scaled;
    acc_t   lo;
    acc_t   hi;
    biased = acc + acc_t'(q.bias);
    prod   = longint'(biased) * longint'(acc_t'(q.multiplier));
    prod   = prod >>> q.shift[5:0];
    scaled = acc_t'(prod[31:0]) + acc_t'(q.output_offset);
    lo     = acc_t'(q.act_min);
    hi     = acc_t'(q.act_max);
    if (scaled < lo) begin
      scaled = lo;
    end else if (scaled > hi) begin
      scaled = hi;
    end
    return word_t'(scaled);
  endfunction

  task automatic check_word(string label, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, label, expected, actual);
      error_count++;
    end
  endtask

  // status bits are compared as {done, busy}
  task automatic check_status(string label, logic [1:0] expected, word_t ctrl);
    logic [1:0] actual;
    actual = {ctrl[CTRL_DONE_BIT], ctrl[CTRL_BUSY_BIT]};
    if (actual !== expected) begin
      $display("FAIL %s %s: expected done,busy %b, actual %b", cur_test, label, expected,
               actual);
      error_count++;
    end
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    test_errors = error_count;
    tests_run++;
  endtask

  task automatic end_test();
    if (error_count == test_errors) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, error_count - test_errors);
      tests_failed++;
    end
  endtask

  task automatic start_run();
    wb_write(reg_adr(REG_CONTROL), 32'h1);
  endtask

  // poll the control register until done reads 1
  task automatic wait_done();
    word_t ctrl;
    int    polls;
    polls = 0;
    do begin
      wb_read(reg_adr(REG_CONTROL), ctrl);
      polls++;
    end while (ctrl[CTRL_DONE_BIT] !== 1'b1 && polls < POLL_LIMIT);
    if (ctrl[CTRL_DONE_BIT] !== 1'b1) begin
      $display("ERROR %s: done did not rise after %0d status reads", cur_test, POLL_LIMIT);
      error_count++;
    end
  endtask

  task automatic run_and_check(string label);
    word_t expected;
    word_t actual;
    expected = requant_model(dot_model(), qcfg);
    start_run();
    wait_done();
    wb_read(reg_adr(REG_RESULT), actual);
    check_word(label, expected, actual);
  endtask

  task automatic reset_values();
    word_t rd;
    begin_test("reset_values");
    wb_read(reg_adr(REG_CONTROL), rd);
    check_status("control", 2'b00, rd);
    wb_read(reg_adr(REG_RESULT), rd);
    check_word("result", '0, rd);
    wb_read(reg_adr(10'd13), rd);
    check_word("unused register", '0, rd);
    wb_read({REGION_INPUT, 10'd5}, rd);
    check_word("input buffer read", '0, rd);
    end_test();
  endtask

  // depth 16 and filter start 7 leave exactly one step
  task automatic single_step();
    begin_test("single_step");
    fill_buffers();
    set_quant(32'd0, 32'd1, 32'd0, WIDE_MIN, WIDE_MAX, 32'd0);
    set_layer(32'd128, 32'd16, 32'd1, 32'd0, 32'd7);
    run_and_check("one step");
    end_test();
  endtask

  task automatic multi_step_windows();
    begin_test("multi_step_windows");
    set_quant(32'd0, 32'd1, 32'd0, WIDE_MIN, WIDE_MAX, 32'd0);
    // kernel range is 96 bytes, input range far longer
    set_layer(32'd128, 32'd16, 32'd40, 32'd3, 32'd2);
    run_and_check("kernel ends first");
    // kernel range is 224 bytes, input range only 128
    set_layer(32'hffff_fffb, 32'd32, 32'd6, 32'd2, 32'd1);
    run_and_check("input ends first");
    end_test();
  endtask

  task automatic requant_rules();
    word_t u;
    begin_test("requant_rules");
    set_layer(32'd128, 32'd16, 32'd40, 32'd3, 32'd2);
    set_quant(32'd1000, 32'd3, 32'd2, WIDE_MIN, WIDE_MAX, -20);
    run_and_check("bias mult shift offset");
    set_quant(-300, -7, 32'd5, WIDE_MIN, WIDE_MAX, 32'd9);
    run_and_check("negative multiplier");
    // bounds placed just above and just below the unclamped value
    u = requant_model(dot_model(), qcfg);
    set_quant(qcfg.bias, qcfg.multiplier, qcfg.shift, u + 1, u + 50, qcfg.output_offset);
    run_and_check("clamp at act_min");
    set_quant(qcfg.bias, qcfg.multiplier, qcfg.shift, u - 50, u - 1, qcfg.output_offset);
    run_and_check("clamp at act_max");
    end_test();
  endtask

  task automatic start_while_busy();
    word_t first;
    word_t rd;
    begin_test("start_while_busy");
    set_quant(32'd0, 32'd1, 32'd0, WIDE_MIN, WIDE_MAX, 32'd0);
    set_layer(32'd128, 32'd32, 32'd6, 32'd2, 32'd1);
    first = requant_model(dot_model(), qcfg);
    start_run();
    // the sequencer took its addresses at start, a new filter start waits for the next run
    wb_write(reg_adr(REG_START_FLT), 32'd4);
    lcfg.start_filter_x = 32'd4;
    start_run();
    wb_read(reg_adr(REG_CONTROL), rd);
    check_status("busy during run", 2'b01, rd);
    wait_done();
    wb_read(reg_adr(REG_RESULT), rd);
    check_word("first result", first, rd);
    // a fresh start clears done until the new result lands
    start_run();
    wb_read(reg_adr(REG_CONTROL), rd);
    check_status("done cleared", 2'b01, rd);
    wait_done();
    wb_read(reg_adr(REG_RESULT), rd);
    check_word("second result", requant_model(dot_model(), qcfg), rd);
    end_test();
  endtask

  // filter start at the kernel length leaves no bytes, the sum is 0
  task automatic empty_window();
    begin_test("empty_window");
    set_layer(32'd128, 32'd16, 32'd40, 32'd0, 32'(KERNEL_LENGTH));
    set_quant(32'd50, 32'd2, 32'd1, WIDE_MIN, WIDE_MAX, 32'd7);
    run_and_check("empty window");
    end_test();
  endtask

  initial begin
    rst_n  = 1'b0;
    wb_req = '0;
    lcfg   = '0;
    qcfg   = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_values();
    single_step();
    multi_step_windows();
    requant_rules();
    start_while_busy();
    empty_window();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hw/conv_types_pkg.sv
hw/conv_bus_pkg.sv
hw/conv_regs.sv
hw/word_buffer.sv
hw/window_sequencer.sv
hw/dot_accumulator.sv
hw/requantizer.sv
hw/conv1d_top.sv
verification/conv1d_sva.sv
verification/conv1d_tb.sv

/* run.sh */
#!/bin/sh
# build the conv1d testbench with Verilator, run it, and exit 0 only on a pass

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module conv1d_tb -f compile.f \
    --Mdir obj_dir -o conv1d_sim > build.log 2>&1; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/conv1d_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi

echo "pass message not found in sim.log"
exit 1
